/* verilog.f */
common/rv32i_pkg.sv
execute/alu.sv
execute/cmp.sv
execute/execute.sv
source/pipe_ctrl.sv
source/mem_stage.sv
source/writeback.sv
source/exec_backend.sv
bench/wb_mem_model.sv
bench/tb_exec_backend.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_exec_backend
RTL_TOP ?= exec_backend
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_TEXT ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_exec_backend.sv */
module tb_exec_backend;
	import rv32i_pkg::*;

	localparam int instr_budget = 100; // generous count of issued instructions

	logic clk, rst_n;
	logic in_valid, in_ready;
	rv32i_word in_pc, in_rs1, in_rs2, in_imm;
	exec_op in_op;
	alu_ops in_aluop;
	rv32i_funct3 in_funct3;
	rv32i_reg in_rs1_num, in_rs2_num, in_rd;
	logic rf_we, redirect_valid;
	rv32i_reg rf_rd;
	rv32i_word rf_data, redirect_pc;
	logic bus_cyc, bus_stb, bus_we, bus_ack;
	logic [3:0] bus_sel;
	rv32i_word bus_adr, bus_dat_w, bus_dat_r;

	rv32i_word rf_model [32];
	logic [31:0] ref_mem [256];
	int errors;
	int issued;

	exec_backend #(.reset_pc(32'h0000_0100)) UUT (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_pc(in_pc), .in_op(in_op), .in_aluop(in_aluop),
		.in_funct3(in_funct3), .in_rs1_num(in_rs1_num), .in_rs2_num(in_rs2_num),
		.in_rs1(in_rs1), .in_rs2(in_rs2), .in_imm(in_imm), .in_rd(in_rd),
		.in_ready(in_ready), .rf_we(rf_we), .rf_rd(rf_rd), .rf_data(rf_data),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.bus_cyc(bus_cyc), .bus_stb(bus_stb), .bus_we(bus_we), .bus_adr(bus_adr),
		.bus_sel(bus_sel), .bus_dat_w(bus_dat_w), .bus_dat_r(bus_dat_r), .bus_ack(bus_ack)
	);

	wb_mem_model mem_model (
		.clk(clk), .rst_n(rst_n), .cyc(bus_cyc), .stb(bus_stb), .we(bus_we),
		.adr(bus_adr), .sel(bus_sel), .dat_w(bus_dat_w), .dat_r(bus_dat_r), .ack(bus_ack)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// a write to x0 lands here too, so the x0 check sees it
	always @(posedge clk)
		if (rf_we)
			rf_model[rf_rd] <= rf_data;

	initial begin
		#(100 * (200 * instr_budget + 1000));
		$display("timeout, pipeline stopped making progress");
		$display("Some tests failed");
		$finish;
	end

	function automatic rv32i_word alu_rule(input alu_ops fn, input rv32i_word a,
			input rv32i_word b);
		int sh;
		sh = b % 32;
		case (fn)
			alu_add: return a + b;
			alu_sub: return a + ~b + 1;
			alu_sll: return a << sh;
			alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			alu_sltu: return (a < b) ? 32'd1 : 32'd0;
			alu_xor: return a ^ b;
			alu_srl: return a >> sh;
			alu_sra: return $unsigned($signed(a) >>> sh);
			alu_or: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_rule(input rv32i_funct3 f3, input rv32i_word a,
			input rv32i_word b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return !($signed(a) < $signed(b));
			3'd6: return a < b;
			default: return !(a < b);
		endcase
	endfunction

	function automatic rv32i_word load_rule(input rv32i_funct3 f3, input rv32i_word w,
			input int off);
		rv32i_word s;
		s = w >> (8 * off);
		case (f3)
			3'd0: return {{24{s[7]}}, s[7:0]};
			3'd1: return {{16{s[15]}}, s[15:0]};
			3'd4: return {24'd0, s[7:0]};
			3'd5: return {16'd0, s[15:0]};
			default: return s;
		endcase
	endfunction

	task automatic store_rule(input rv32i_funct3 f3, input rv32i_word addr, input rv32i_word data);
		int bytes;
		bytes = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
		for (int j = 0; j < bytes; j++)
			ref_mem[addr[9:2]][8 * (addr[1:0] + j) +: 8] = data[8 * j +: 8];
	endtask

	task automatic issue(input exec_op op, input alu_ops fn, input rv32i_funct3 f3,
			input rv32i_reg rs1n, input rv32i_reg rs2n, input rv32i_reg rd,
			input rv32i_word imm, input rv32i_word pc);
		logic accepted;
		accepted = 1'b0;
		in_valid = 1'b1;
		in_op = op;
		in_aluop = fn;
		in_funct3 = f3;
		in_rs1_num = rs1n;
		in_rs2_num = rs2n;
		in_rd = rd;
		in_imm = imm;
		in_pc = pc;
		while (!accepted) begin
			in_rs1 = rf_model[rs1n]; // register file read, stale while a write is in flight
			in_rs2 = rf_model[rs2n];
			@(negedge clk);
			accepted = in_ready;
			@(posedge clk);
			#10;
		end
		in_valid = 1'b0;
		issued++;
	endtask

	task automatic drain();
		int quiet;
		quiet = 0;
		while (quiet < 3) begin
			@(negedge clk);
			if (in_ready && !bus_cyc && !rf_we)
				quiet++;
			else
				quiet = 0;
		end
		@(posedge clk);
		#10;
	endtask

	task automatic check_val(input string name, input rv32i_word got, input rv32i_word exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(input int n, input rv32i_word exp);
		check_val($sformatf("x%0d", n), rf_model[n], exp);
	endtask

	task automatic check_memory();
		for (int i = 0; i < 256; i++)
			check_val($sformatf("mem[%0d]", i), mem_model.mem[i], ref_mem[i]);
	endtask

	task automatic test_reset();
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			if (!in_ready || bus_cyc || rf_we || redirect_valid) begin
				errors++;
				$display("after reset: in_ready low or bus_cyc, rf_we or redirect high at %0t",
					$time);
			end
		end
		@(posedge clk);
		#10;
	endtask

	task automatic test_alu();
		rv32i_word a, b, imm;
		a = 32'h8000_0f0f;
		b = 32'h0000_0024;
		imm = 32'hffff_f803;
		issue(op_lui, alu_add, 3'd0, 5'd0, 5'd0, 5'd1, 32'h8000_1000, 32'h100);
		issue(op_alu_imm, alu_add, 3'd0, 5'd1, 5'd0, 5'd1, 32'hffff_ff0f, 32'h104);
		issue(op_alu_imm, alu_add, 3'd0, 5'd0, 5'd0, 5'd2, b, 32'h108);
		for (int i = 0; i < 10; i++) begin
			issue(op_alu_reg, alu_ops'(i), 3'd0, 5'd1, 5'd2, rv32i_reg'(3 + i), 32'h0, 32'h10c);
			issue(op_alu_imm, alu_ops'(i), 3'd0, 5'd1, 5'd0, rv32i_reg'(13 + i), imm, 32'h110);
		end
		issue(op_lui, alu_add, 3'd0, 5'd0, 5'd0, 5'd23, 32'h1234_5000, 32'h114);
		issue(op_auipc, alu_add, 3'd0, 5'd0, 5'd0, 5'd24, 32'h0000_2000, 32'h100);
		drain();
		check_reg(1, a);
		check_reg(2, b);
		for (int i = 0; i < 10; i++) begin
			check_reg(3 + i, alu_rule(alu_ops'(i), a, b));
			check_reg(13 + i, alu_rule(alu_ops'(i), a, imm));
		end
		check_reg(23, 32'h1234_5000);
		check_reg(24, 32'h0000_2100);
	endtask

	task automatic test_dependencies();
		issue(op_alu_imm, alu_add, 3'd0, 5'd0, 5'd0, 5'd5, 32'd7, 32'h200);
		issue(op_alu_reg, alu_add, 3'd0, 5'd5, 5'd5, 5'd6, 32'd0, 32'h204); // from memory stage
		issue(op_alu_reg, alu_sub, 3'd0, 5'd6, 5'd5, 5'd7, 32'd0, 32'h208); // x5 from writeback
		issue(op_alu_imm, alu_add, 3'd0, 5'd0, 5'd0, 5'd0, 32'd99, 32'h20c);
		issue(op_alu_reg, alu_add, 3'd0, 5'd0, 5'd7, 5'd8, 32'd0, 32'h210);
		issue(op_alu_imm, alu_add, 3'd0, 5'd0, 5'd0, 5'd9, 32'd1, 32'h214);
		drain();
		check_reg(0, 32'd0);
		check_reg(5, 32'd7);
		check_reg(6, 32'd14);
		check_reg(7, 32'd7);
		check_reg(8, 32'd7);
		check_reg(9, 32'd1);
	endtask

	task automatic check_redirect(input logic exp_valid, input rv32i_word exp_pc);
		@(negedge clk);
		check_val("redirect_valid", {31'd0, redirect_valid}, {31'd0, exp_valid});
		if (exp_valid)
			check_val("redirect_pc", redirect_pc, exp_pc);
		@(posedge clk);
		#10;
	endtask

	task automatic test_branches();
		rv32i_funct3 conds [6];
		rv32i_reg ra, rb;
		rv32i_word va, vb, pc, imm;
		conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		issue(op_alu_imm, alu_add, 3'd0, 5'd0, 5'd0, 5'd10, 32'd5, 32'h300);
		issue(op_alu_imm, alu_add, 3'd0, 5'd0, 5'd0, 5'd11, 32'hffff_fffd, 32'h304);
		issue(op_alu_imm, alu_add, 3'd0, 5'd0, 5'd0, 5'd12, 32'd0, 32'h308);
		drain();
		for (int c = 0; c < 6; c++) begin
			for (int p = 0; p < 3; p++) begin
				ra = (p == 1) ? 5'd11 : 5'd10;
				rb = (p == 0) ? 5'd11 : 5'd10;
				va = (ra == 5'd10) ? 32'd5 : 32'hffff_fffd;
				vb = (rb == 5'd10) ? 32'd5 : 32'hffff_fffd;
				pc = 32'h400 + 32'(16 * (3 * c + p));
				imm = p[0] ? 32'hffff_ffe0 : 32'h0000_0040;
				issue(op_br, alu_add, conds[c], ra, rb, 5'd12, imm, pc);
				check_redirect(branch_rule(conds[c], va, vb), pc + imm);
			end
		end
		issue(op_jal, alu_add, 3'd0, 5'd0, 5'd0, 5'd13, 32'h80, 32'h600);
		check_redirect(1'b1, 32'h680);
		issue(op_jalr, alu_add, 3'd0, 5'd11, 5'd0, 5'd14, 32'h108, 32'h700);
		check_redirect(1'b1, 32'h104);
		drain();
		check_reg(12, 32'd0); // branches write nothing
		check_reg(13, 32'h604);
		check_reg(14, 32'h704);
	endtask

	task automatic test_stores();
		rv32i_word data, imm;
		data = 32'ha1b2_c3d4;
		issue(op_alu_imm, alu_add, 3'd0, 5'd0, 5'd0, 5'd20, 32'h40, 32'h800);
		issue(op_lui, alu_add, 3'd0, 5'd0, 5'd0, 5'd21, 32'ha1b2_c000, 32'h804);
		issue(op_alu_imm, alu_add, 3'd0, 5'd21, 5'd0, 5'd21, 32'h3d4, 32'h808);
		for (int k = 0; k < 7; k++) begin
			imm = 32'(4 * k) + ((k < 4) ? 32'(k) : (k == 5) ? 32'd2 : 32'd0);
			issue(op_store, alu_add, (k < 4) ? 3'd0 : (k < 6) ? 3'd1 : 3'd2,
				5'd20, 5'd21, 5'd0, imm, 32'h80c);
			store_rule((k < 4) ? 3'd0 : (k < 6) ? 3'd1 : 3'd2, 32'h40 + imm, data);
		end
		drain();
		check_memory();
	endtask

	task automatic test_loads();
		rv32i_funct3 f3;
		int w, off;
		for (int n = 0; n < 13; n++) begin
			f3 = (n < 8) ? (n[0] ? 3'd4 : 3'd0) : (n < 12) ? (n[0] ? 3'd5 : 3'd1) : 3'd2;
			off = (n < 8) ? n / 2 : (n < 12) ? 2 * ((n - 8) / 2) : 0;
			w = 80 + n;
			issue(op_load, alu_add, f3, 5'd20, 5'd0, 5'd25, 32'(4 * w - 64 + off), 32'h900);
			drain();
			check_reg(25, load_rule(f3, ref_mem[w], off));
		end
		// dependent add straight behind the load
		issue(op_load, alu_add, 3'd2, 5'd20, 5'd0, 5'd26, 32'd24, 32'h904);
		issue(op_alu_imm, alu_add, 3'd0, 5'd26, 5'd0, 5'd27, 32'd1, 32'h908);
		drain();
		check_reg(26, ref_mem[22]);
		check_reg(27, ref_mem[22] + 32'd1);
		check_memory(); // loads leave memory untouched
	endtask

	initial begin
		errors = 0;
		issued = 0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_pc = '0;
		in_op = op_alu_imm;
		in_aluop = alu_add;
		in_funct3 = '0;
		in_rs1_num = '0;
		in_rs2_num = '0;
		in_rs1 = '0;
		in_rs2 = '0;
		in_imm = '0;
		in_rd = '0;
		for (int i = 0; i < 32; i++)
			rf_model[i] = '0;
		repeat (2) @(posedge clk);
		#10;
		rst_n = 1'b1;
		for (int i = 0; i < 256; i++)
			ref_mem[i] = mem_model.mem[i];
		test_reset();
		test_alu();
		test_dependencies();
		test_branches();
		test_stores();
		test_loads();
		$display("%0d instructions issued, %0d errors", issued, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule : tb_exec_backend

/* bench/wb_mem_model.sv */
module wb_mem_model (
	input logic clk,
	input logic rst_n,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [31:0] adr,
	input logic [3:0] sel,
	input logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic ack
);

	logic [31:0] mem [256];
	logic [15:0] lfsr, lfsr_1, lfsr_2;
	logic [1:0] wait_cnt;
	logic busy;

	// fibonacci taps 16 14 13 11, output is the new bit
	function automatic logic [15:0] lfsr_step(input logic [15:0] l);
		return {l[14:0], l[15] ^ l[13] ^ l[12] ^ l[10]};
	endfunction

	function automatic logic [31:0] fill_word(input int i);
		return 32'h8f4e_c3a1 ^ {4{i[7:0]}};
	endfunction

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(i);
	end

	assign lfsr_1 = lfsr_step(lfsr);
	assign lfsr_2 = lfsr_step(lfsr_1);

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack <= 1'b0;
			busy <= 1'b0;
			wait_cnt <= 2'd0;
			lfsr <= 16'd54;
			dat_r <= '0;
		end else begin
			ack <= 1'b0;
			if (cyc && stb && !ack) begin
				if (!busy) begin
					busy <= 1'b1;
					wait_cnt <= {lfsr_2[0], lfsr_1[0]}; // two bits, two steps
					lfsr <= lfsr_2;
				end else if (wait_cnt == 2'd0) begin
					busy <= 1'b0;
					ack <= 1'b1;
					dat_r <= mem[adr[9:2]];
					if (we) begin
						for (int j = 0; j < 4; j++)
							if (sel[j])
								mem[adr[9:2]][8*j +: 8] <= dat_w[8*j +: 8];
					end
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end
		end
	end

endmodule : wb_mem_model

/* source/exec_backend.sv */
module exec_backend #(
	parameter rv32i_pkg::rv32i_word reset_pc = 32'h0000_0000
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input rv32i_pkg::rv32i_word in_pc,
	input rv32i_pkg::exec_op in_op,
	input rv32i_pkg::alu_ops in_aluop,
	input rv32i_pkg::rv32i_funct3 in_funct3,
	input rv32i_pkg::rv32i_reg in_rs1_num,
	input rv32i_pkg::rv32i_reg in_rs2_num,
	input rv32i_pkg::rv32i_word in_rs1,
	input rv32i_pkg::rv32i_word in_rs2,
	input rv32i_pkg::rv32i_word in_imm,
	input rv32i_pkg::rv32i_reg in_rd,
	output logic in_ready,
	output logic rf_we,
	output rv32i_pkg::rv32i_reg rf_rd,
	output rv32i_pkg::rv32i_word rf_data,
	output logic redirect_valid,
	output rv32i_pkg::rv32i_word redirect_pc,
	output logic bus_cyc,
	output logic bus_stb,
	output logic bus_we,
	output rv32i_pkg::rv32i_word bus_adr,
	output logic [3:0] bus_sel,
	output rv32i_pkg::rv32i_word bus_dat_w,
	input rv32i_pkg::rv32i_word bus_dat_r,
	input logic bus_ack
);
	import rv32i_pkg::*;

	fwd_sel fwd_rs1, fwd_rs2;
	logic ex_advance, mem_advance;
	logic mem_valid;
	exec_op mem_op;
	rv32i_funct3 mem_funct3;
	rv32i_reg mem_rd;
	rv32i_word mem_result, mem_store_data, mem_fwd_data;
	logic wb_valid, wb_writes;
	rv32i_reg wb_rd;
	rv32i_word wb_value;

	pipe_ctrl ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_rs1_num(in_rs1_num),
		.in_rs2_num(in_rs2_num),
		.mem_valid(mem_valid),
		.mem_op(mem_op),
		.mem_rd(mem_rd),
		.rf_we(rf_we),
		.rf_rd(rf_rd),
		.bus_ack(bus_ack),
		.in_ready(in_ready),
		.fwd_rs1(fwd_rs1),
		.fwd_rs2(fwd_rs2),
		.ex_advance(ex_advance),
		.mem_advance(mem_advance),
		.bus_cyc(bus_cyc),
		.bus_stb(bus_stb)
	);

	execute #(.reset_pc(reset_pc)) ex_stage (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid && in_ready), // only accepted instructions enter
		.in_pc(in_pc),
		.in_op(in_op),
		.in_aluop(in_aluop),
		.in_funct3(in_funct3),
		.in_rs1(in_rs1),
		.in_rs2(in_rs2),
		.in_imm(in_imm),
		.in_rd(in_rd),
		.fwd_rs1(fwd_rs1),
		.fwd_rs2(fwd_rs2),
		.mem_fwd_data(mem_fwd_data),
		.rf_data(rf_data),
		.ex_advance(ex_advance),
		.mem_valid(mem_valid),
		.mem_op(mem_op),
		.mem_funct3(mem_funct3),
		.mem_rd(mem_rd),
		.mem_result(mem_result),
		.mem_store_data(mem_store_data),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc)
	);

	mem_stage mem (
		.clk(clk),
		.rst_n(rst_n),
		.mem_valid(mem_valid),
		.mem_op(mem_op),
		.mem_funct3(mem_funct3),
		.mem_rd(mem_rd),
		.mem_result(mem_result),
		.mem_store_data(mem_store_data),
		.mem_advance(mem_advance),
		.bus_dat_r(bus_dat_r),
		.bus_we(bus_we),
		.bus_adr(bus_adr),
		.bus_sel(bus_sel),
		.bus_dat_w(bus_dat_w),
		.mem_fwd_data(mem_fwd_data),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_value(wb_value),
		.wb_writes(wb_writes)
	);

	writeback wb (
		.clk(clk),
		.rst_n(rst_n),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_value(wb_value),
		.wb_writes(wb_writes),
		.rf_we(rf_we),
		.rf_rd(rf_rd),
		.rf_data(rf_data)
	);

endmodule : exec_backend

/* source/writeback.sv */
module writeback (
	input logic clk,
	input logic rst_n,
	input logic wb_valid,
	input rv32i_pkg::rv32i_reg wb_rd,
	input rv32i_pkg::rv32i_word wb_value,
	input logic wb_writes,
	output logic rf_we,
	output rv32i_pkg::rv32i_reg rf_rd,
	output rv32i_pkg::rv32i_word rf_data
);
	import rv32i_pkg::*;

	rv32i_reg last_rd;
	rv32i_word last_data;

	assign rf_we = wb_valid && wb_writes && (wb_rd != '0);

	// port keeps the last write between writes
	assign rf_rd = rf_we ? wb_rd : last_rd;
	assign rf_data = rf_we ? wb_value : last_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_rd <= '0;
			last_data <= '0;
		end else if (rf_we) begin
			last_rd <= wb_rd;
			last_data <= wb_value;
		end
	end

endmodule : writeback

/* source/mem_stage.sv */
module mem_stage (
	input logic clk,
	input logic rst_n,
	input logic mem_valid,
	input rv32i_pkg::exec_op mem_op,
	input rv32i_pkg::rv32i_funct3 mem_funct3,
	input rv32i_pkg::rv32i_reg mem_rd,
	input rv32i_pkg::rv32i_word mem_result,
	input rv32i_pkg::rv32i_word mem_store_data,
	input logic mem_advance,
	input rv32i_pkg::rv32i_word bus_dat_r,
	output logic bus_we,
	output rv32i_pkg::rv32i_word bus_adr,
	output logic [3:0] bus_sel,
	output rv32i_pkg::rv32i_word bus_dat_w,
	output rv32i_pkg::rv32i_word mem_fwd_data,
	output logic wb_valid,
	output rv32i_pkg::rv32i_reg wb_rd,
	output rv32i_pkg::rv32i_word wb_value,
	output logic wb_writes
);
	import rv32i_pkg::*;

	logic [1:0] offset;
	logic [3:0] sel_base;
	logic is_load;
	rv32i_word load_lanes;
	rv32i_word load_data;

	assign offset = mem_result[1:0];
	assign is_load = (mem_op == op_load);

	assign bus_adr = {mem_result[31:2], 2'b00};
	assign bus_we = mem_valid && mem_op == op_store;

	always_comb begin
		case (mem_funct3[1:0])
			2'b00: sel_base = 4'b0001;
			2'b01: sel_base = 4'b0011;
			default: sel_base = 4'b1111;
		endcase
	end

	assign bus_sel = sel_base << offset;
	assign bus_dat_w = mem_store_data << {offset, 3'b000};

	// bring the addressed bytes down to lane 0
	assign load_lanes = bus_dat_r >> {offset, 3'b000};

	always_comb begin
		case (mem_funct3)
			3'b000: load_data = {{24{load_lanes[7]}}, load_lanes[7:0]}; // lb
			3'b001: load_data = {{16{load_lanes[15]}}, load_lanes[15:0]};
			3'b100: load_data = {24'b0, load_lanes[7:0]}; // lbu
			3'b101: load_data = {16'b0, load_lanes[15:0]};
			default: load_data = load_lanes;
		endcase
	end

	assign mem_fwd_data = mem_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= mem_valid && mem_advance; // bubble while held
	end

	always_ff @(posedge clk) begin
		if (mem_valid && mem_advance) begin
			wb_rd <= mem_rd;
			wb_value <= is_load ? load_data : mem_result;
			wb_writes <= !(mem_op == op_store || mem_op == op_br);
		end
	end

endmodule : mem_stage

/* source/pipe_ctrl.sv */
module pipe_ctrl (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input rv32i_pkg::rv32i_reg in_rs1_num,
	input rv32i_pkg::rv32i_reg in_rs2_num,
	input logic mem_valid,
	input rv32i_pkg::exec_op mem_op,
	input rv32i_pkg::rv32i_reg mem_rd,
	input logic rf_we,
	input rv32i_pkg::rv32i_reg rf_rd,
	input logic bus_ack,
	output logic in_ready,
	output rv32i_pkg::fwd_sel fwd_rs1,
	output rv32i_pkg::fwd_sel fwd_rs2,
	output logic ex_advance,
	output logic mem_advance,
	output logic bus_cyc,
	output logic bus_stb
);
	import rv32i_pkg::*;

	bus_state state, state_next;
	logic mem_access;
	logic mem_writes;
	logic load_use;

	// memory stage wins over writeback, x0 never forwarded
	function automatic fwd_sel pick_src(input rv32i_reg rs_num);
		fwd_sel src;
		src = fwd_none;
		if (rs_num != '0) begin
			if (mem_writes && mem_rd == rs_num)
				src = fwd_mem;
			else if (rf_we && rf_rd == rs_num)
				src = fwd_wb;
		end
		return src;
	endfunction

	assign mem_access = mem_valid && (mem_op == op_load || mem_op == op_store);
	// loads are not ready yet, they interlock instead
	assign mem_writes = mem_valid && (mem_op inside {op_alu_reg, op_alu_imm, op_lui,
		op_auipc, op_jal, op_jalr});

	always_comb begin
		fwd_rs1 = pick_src(in_rs1_num);
		fwd_rs2 = pick_src(in_rs2_num);
	end

	assign load_use = in_valid && mem_valid && mem_op == op_load && mem_rd != '0 &&
		(mem_rd == in_rs1_num || mem_rd == in_rs2_num);

	always_comb begin
		state_next = state;
		case (state)
			bus_idle: if (mem_access) state_next = bus_access;
			bus_access: if (bus_ack) state_next = bus_release;
			bus_release: state_next = mem_access ? bus_access : bus_idle; // next op already in
			default: state_next = bus_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= bus_idle;
		else
			state <= state_next;
	end

	assign bus_cyc = (state == bus_access);
	assign bus_stb = (state == bus_access);

	assign mem_advance = !mem_access || (state == bus_access && bus_ack);
	assign ex_advance = mem_advance;
	assign in_ready = ex_advance && !load_use;

endmodule : pipe_ctrl

/* execute/execute.sv */
module execute #(
	parameter rv32i_pkg::rv32i_word reset_pc = 32'h0000_0000
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input rv32i_pkg::rv32i_word in_pc,
	input rv32i_pkg::exec_op in_op,
	input rv32i_pkg::alu_ops in_aluop,
	input rv32i_pkg::rv32i_funct3 in_funct3,
	input rv32i_pkg::rv32i_word in_rs1,
	input rv32i_pkg::rv32i_word in_rs2,
	input rv32i_pkg::rv32i_word in_imm,
	input rv32i_pkg::rv32i_reg in_rd,
	input rv32i_pkg::fwd_sel fwd_rs1,
	input rv32i_pkg::fwd_sel fwd_rs2,
	input rv32i_pkg::rv32i_word mem_fwd_data,
	input rv32i_pkg::rv32i_word rf_data,
	input logic ex_advance,
	output logic mem_valid,
	output rv32i_pkg::exec_op mem_op,
	output rv32i_pkg::rv32i_funct3 mem_funct3,
	output rv32i_pkg::rv32i_reg mem_rd,
	output rv32i_pkg::rv32i_word mem_result,
	output rv32i_pkg::rv32i_word mem_store_data,
	output logic redirect_valid,
	output rv32i_pkg::rv32i_word redirect_pc
);
	import rv32i_pkg::*;

	rv32i_word rs1_val, rs2_val;
	rv32i_word alu_a, alu_b, alu_f;
	rv32i_word br_target, target, result;
	alu_ops alu_fn;
	logic br_en;
	logic taken;

	function automatic rv32i_word fwd_mux(input fwd_sel sel, input rv32i_word reg_val,
			input rv32i_word mem_val, input rv32i_word wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign rs1_val = fwd_mux(fwd_rs1, in_rs1, mem_fwd_data, rf_data);
	assign rs2_val = fwd_mux(fwd_rs2, in_rs2, mem_fwd_data, rf_data);

	assign alu_a = (in_op == op_auipc) ? in_pc : rs1_val;
	assign alu_b = (in_op == op_alu_reg) ? rs2_val : in_imm;
	// address calc and auipc always add
	assign alu_fn = (in_op == op_alu_reg || in_op == op_alu_imm) ? in_aluop : alu_add;

	alu alu_unit (
		.aluop(alu_fn),
		.a(alu_a),
		.b(alu_b),
		.f(alu_f)
	);

	cmp cmp_unit (
		.funct3(in_funct3),
		.a(rs1_val),
		.b(rs2_val),
		.br_en(br_en)
	);

	assign br_target = in_pc + in_imm; // own adder, runs beside the alu
	assign target = (in_op == op_jalr) ? {alu_f[31:1], 1'b0} : br_target;
	assign taken = (in_op == op_br && br_en) || in_op == op_jal || in_op == op_jalr;

	always_comb begin
		case (in_op)
			op_lui: result = in_imm;
			op_jal, op_jalr: result = in_pc + 32'd4; // link
			default: result = alu_f;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_valid <= 1'b0;
			redirect_valid <= 1'b0;
			redirect_pc <= reset_pc;
		end else if (ex_advance) begin
			mem_valid <= in_valid; // low means bubble
			redirect_valid <= in_valid && taken;
			if (in_valid)
				redirect_pc <= target;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_advance && in_valid) begin
			mem_op <= in_op;
			mem_funct3 <= in_funct3;
			mem_rd <= in_rd;
			mem_result <= result;
			mem_store_data <= rs2_val;
		end
	end

endmodule : execute

/* execute/cmp.sv */
module cmp (
	input rv32i_pkg::rv32i_funct3 funct3,
	input rv32i_pkg::rv32i_word a,
	input rv32i_pkg::rv32i_word b,
	output logic br_en
);

	always_comb begin
		case (funct3)
			3'b000: br_en = (a == b); // beq
			3'b001: br_en = (a != b);
			3'b100: br_en = ($signed(a) < $signed(b)); // blt
			3'b101: br_en = ($signed(a) >= $signed(b));
			3'b110: br_en = (a < b); // bltu
			3'b111: br_en = (a >= b);
			default: br_en = 1'b0;
		endcase
	end

endmodule : cmp

/* execute/alu.sv */
module alu (
	input rv32i_pkg::alu_ops aluop,
	input rv32i_pkg::rv32i_word a,
	input rv32i_pkg::rv32i_word b,
	output rv32i_pkg::rv32i_word f
);
	import rv32i_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (aluop)
			alu_add: f = a + b;
			alu_sub: f = a - b;
			alu_sll: f = a << shamt;
			alu_slt: f = {31'b0, $signed(a) < $signed(b)};
			alu_sltu: f = {31'b0, a < b};
			alu_xor: f = a ^ b;
			alu_srl: f = a >> shamt;
			alu_sra: f = $signed(a) >>> shamt;
			alu_or: f = a | b;
			alu_and: f = a & b;
			default: f = a + b;
		endcase
	end

endmodule : alu

/* common/rv32i_pkg.sv */
package rv32i_pkg;

	typedef logic [31:0] rv32i_word;
	typedef logic [4:0] rv32i_reg;
	typedef logic [2:0] rv32i_funct3; // branch condition or load/store size

	typedef enum logic [3:0] {
		op_alu_reg,
		op_alu_imm,
		op_lui,
		op_auipc,
		op_br,
		op_jal,
		op_jalr,
		op_load,
		op_store
	} exec_op;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_ops;

	// operand source at issue
	typedef enum logic [1:0] {
		fwd_none,
		fwd_mem,
		fwd_wb
	} fwd_sel;

	typedef enum logic [1:0] {
		bus_idle,
		bus_access,
		bus_release
	} bus_state;

endpackage : rv32i_pkg
